// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  typedef logic [31:0] xlen_t;  // address, instruction and data word
  typedef logic [3:0]  strb_t;  // one bit per byte lane

  // addi x0, x0, 0
  localparam xlen_t NOP_INST = 32'h0000_0013;
  localparam xlen_t RESET_PC = 32'h0000_0000;

  typedef enum logic [1:0] {
    IDLE,       // first fetch after reset
    REQ,        // fetch req high, waiting for ack
    WAIT_DROP,  // req dropped, waiting for ack to fall
    HOLD        // output full and stalled
  } pc_state_e;

  typedef enum logic [2:0] {
    LOOKUP,
    RESPOND,      // line filled, answer from array
    REFILL_REQ,
    REFILL_DROP,
    DONE_DROP     // ack high until fetch req falls
  } cache_state_e;

  typedef enum logic [1:0] {
    NONE,
    DATA,
    IFETCH
  } arb_owner_e;

  // power-up content of a memory word
  function automatic xlen_t mem_init_word(input int unsigned idx);
    return (xlen_t'(idx) ^ (32'h13 << 7)) + 32'h13;
  endfunction

endpackage

`default_nettype wire

// File: source/mem_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// four-phase req/ack link
interface mem_req_if import fetch_pkg::*; ();

  logic  req;
  logic  we;
  xlen_t addr;
  xlen_t wdata;
  strb_t wstrb;
  logic  ack;
  xlen_t rdata;  // valid while ack is high

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    output wstrb,
    input  ack,
    input  rdata
  );

  modport responder (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  wstrb,
    output ack,
    output rdata
  );

endinterface

`default_nettype wire

// File: source/pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pc_gen import fetch_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          stall_i,
  input  wire          redirect_i,
  input  wire xlen_t   redirect_pc_i,
  mem_req_if.requester fetch,
  output xlen_t        inst_o,
  output xlen_t        pc_o,
  output logic         inst_valid_o
);

  pc_state_e state_q;
  xlen_t     pc_q;       // next pc to fetch
  xlen_t     inst_q;
  logic      drop_q;     // result of the fetch in flight is stale
  logic      can_issue;
  logic      issue;
  logic      take;
  xlen_t     issue_pc;

  // output slot is free or frees up this cycle
  assign can_issue = !inst_valid_o || !stall_i || redirect_i;
  assign issue_pc  = redirect_i ? redirect_pc_i : pc_q;
  assign issue     = (state_q == IDLE) ||
                     (((state_q == HOLD) || (state_q == WAIT_DROP && !fetch.ack)) && can_issue);
  assign take      = (state_q == REQ) && fetch.ack && !drop_q && !redirect_i;

  assign fetch.we    = 1'b0;  // read only
  assign fetch.wdata = '0;
  assign fetch.wstrb = '0;

  assign inst_o = inst_valid_o ? inst_q : NOP_INST;  // bubble when empty

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      pc_q         <= RESET_PC;
      drop_q       <= 1'b0;
      inst_valid_o <= 1'b0;
      fetch.req    <= 1'b0;
    end else begin
      if (issue) begin
        fetch.req <= 1'b1;
        state_q   <= REQ;
      end else if (state_q == REQ && fetch.ack) begin
        fetch.req <= 1'b0;
        state_q   <= WAIT_DROP;
      end else if (state_q == WAIT_DROP && !fetch.ack) begin
        state_q <= HOLD;  // slot still busy
      end

      if (state_q == REQ && fetch.ack)
        drop_q <= 1'b0;
      else if (state_q == REQ && redirect_i)
        drop_q <= 1'b1;

      if (redirect_i)
        pc_q <= redirect_pc_i;
      else if (take)
        pc_q <= fetch.addr + 32'd4;

      if (redirect_i)
        inst_valid_o <= 1'b0;  // flush same cycle
      else if (take)
        inst_valid_o <= 1'b1;
      else if (!stall_i)
        inst_valid_o <= 1'b0;  // consumed
    end
  end

  always_ff @(posedge clk) begin
    if (issue)
      fetch.addr <= issue_pc;
    if (take) begin
      inst_q <= fetch.rdata;
      pc_o   <= fetch.addr;
    end
  end

  a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    fetch.req |-> fetch.addr[1:0] == 2'b00);

  // a stalled instruction stays put until consumed or flushed
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o && stall_i && !redirect_i |=> inst_valid_o && $stable(pc_o));

endmodule

`default_nettype wire

// File: source/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache import fetch_pkg::*; #(
  parameter int LINES      = 8,
  parameter int LINE_WORDS = 4
) (
  input  wire          clk,
  input  wire          rst_n,
  mem_req_if.responder fetch,
  mem_req_if.requester refill
);

  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(LINES);
  localparam int TAG_W = 30 - IDX_W - OFF_W;

  cache_state_e      state_q;
  logic [LINES-1:0]  valid_q;
  logic [TAG_W-1:0]  tag_q [LINES];
  xlen_t             data_q [LINES*LINE_WORDS];
  logic [OFF_W-1:0]  word_q;  // refill word counter

  logic [TAG_W-1:0]  tag;
  logic [IDX_W-1:0]  idx;
  logic [OFF_W-1:0]  off;
  logic              hit;
  logic              last_word;

  // fetch address is stable for the whole handshake
  assign {tag, idx, off} = fetch.addr[31:2];
  assign hit             = valid_q[idx] && (tag_q[idx] == tag);
  assign last_word       = (word_q == OFF_W'(LINE_WORDS - 1));

  assign refill.addr  = {fetch.addr[31:OFF_W+2], word_q, 2'b00};
  assign refill.we    = 1'b0;
  assign refill.wdata = '0;
  assign refill.wstrb = '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= LOOKUP;
      valid_q    <= '0;
      word_q     <= '0;
      fetch.ack  <= 1'b0;
      refill.req <= 1'b0;
    end else begin
      case (state_q)
        LOOKUP: begin
          if (fetch.req) begin
            if (hit) begin
              fetch.ack <= 1'b1;  // one cycle after req
              state_q   <= DONE_DROP;
            end else begin
              valid_q[idx] <= 1'b0;  // line is being replaced
              refill.req   <= 1'b1;
              state_q      <= REFILL_REQ;
            end
          end
        end
        REFILL_REQ: begin
          if (refill.ack) begin
            refill.req <= 1'b0;
            state_q    <= REFILL_DROP;
          end
        end
        REFILL_DROP: begin
          if (!refill.ack) begin
            word_q <= word_q + 1'b1;  // wraps back to 0 after the last word
            if (last_word) begin
              valid_q[idx] <= 1'b1;
              state_q      <= RESPOND;
            end else begin
              refill.req <= 1'b1;
              state_q    <= REFILL_REQ;
            end
          end
        end
        RESPOND: begin
          fetch.ack <= 1'b1;
          state_q   <= DONE_DROP;
        end
        DONE_DROP: begin
          if (!fetch.req) begin
            fetch.ack <= 1'b0;
            state_q   <= LOOKUP;
          end
        end
        default: state_q <= LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == LOOKUP && fetch.req && !hit)
      tag_q[idx] <= tag;
    if (state_q == REFILL_REQ && refill.ack)
      data_q[{idx, word_q}] <= refill.rdata;
    if (!fetch.ack)
      fetch.rdata <= data_q[{idx, off}];  // frozen while ack is high
  end

  // new refill only after the arbiter has dropped the previous ack
  a_refill_4phase: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(refill.req) |-> !refill.ack);

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import fetch_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  mem_req_if.responder refill,
  mem_req_if.requester mem,
  input  wire          dmem_req_i,
  input  wire          dmem_we_i,
  input  wire xlen_t   dmem_addr_i,
  input  wire xlen_t   dmem_wdata_i,
  input  wire strb_t   dmem_wstrb_i,
  output logic         dmem_ack_o,
  output xlen_t        dmem_rdata_o
);

  arb_owner_e owner_q;
  xlen_t      rdata_q;
  logic       owner_req;
  logic       xfer_done;

  assign owner_req = (owner_q == DATA) ? dmem_req_i : refill.req;

  // whole four-phase cycle finished on both sides
  assign xfer_done = (owner_q != NONE) && !mem.req && !mem.ack &&
                     !dmem_ack_o && !refill.ack;

  assign dmem_rdata_o = rdata_q;
  assign refill.rdata = rdata_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q    <= NONE;
      mem.req    <= 1'b0;
      dmem_ack_o <= 1'b0;
      refill.ack <= 1'b0;
    end else begin
      dmem_ack_o <= (owner_q == DATA) && mem.ack;
      refill.ack <= (owner_q == IFETCH) && mem.ack;
      case (owner_q)
        NONE: begin
          if (dmem_req_i) begin  // data port first
            owner_q <= DATA;
            mem.req <= 1'b1;
          end else if (refill.req) begin
            owner_q <= IFETCH;
            mem.req <= 1'b1;
          end
        end
        default: begin
          if (xfer_done)
            owner_q <= NONE;
          else
            mem.req <= owner_req;
        end
      endcase
    end
  end

  // fields latched at grant and held for the transfer
  always_ff @(posedge clk) begin
    if (owner_q == NONE) begin
      if (dmem_req_i) begin
        mem.we    <= dmem_we_i;
        mem.addr  <= dmem_addr_i;
        mem.wdata <= dmem_wdata_i;
        mem.wstrb <= dmem_wstrb_i;
      end else begin
        mem.we    <= refill.we;
        mem.addr  <= refill.addr;
        mem.wdata <= refill.wdata;
        mem.wstrb <= refill.wstrb;
      end
    end
    if (mem.ack)
      rdata_q <= mem.rdata;
  end

  a_dmem_ack_owner: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_ack_o |-> owner_q == DATA);

  a_refill_ack_owner: assert property (@(posedge clk) disable iff (!rst_n)
    refill.ack |-> owner_q == IFETCH);

endmodule

`default_nettype wire

// File: source/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model import fetch_pkg::*; #(
  parameter int MEM_WORDS   = 1024,
  parameter int MEM_LATENCY = 3
) (
  input  wire          clk,
  input  wire          rst_n,
  mem_req_if.responder mem
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int CW = $clog2(MEM_LATENCY + 1);

  xlen_t          ram [MEM_WORDS];
  logic [CW-1:0]  cnt_q;   // cycles since req was sampled
  logic           busy_q;
  logic           access;
  logic [AW-1:0]  idx;

  assign idx    = mem.addr[AW+1:2];  // word address
  assign access = busy_q && (cnt_q == CW'(MEM_LATENCY));

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      ram[i] = mem_init_word(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      cnt_q   <= '0;
      mem.ack <= 1'b0;
    end else if (mem.ack) begin
      if (!mem.req)
        mem.ack <= 1'b0;  // one cycle after req falls
    end else if (busy_q) begin
      if (access) begin
        busy_q  <= 1'b0;
        mem.ack <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (mem.req) begin
      busy_q <= 1'b1;
      cnt_q  <= CW'(1);
    end
  end

  always @(posedge clk) begin
    if (access) begin
      if (mem.we) begin
        for (int b = 0; b < 4; b++) begin
          if (mem.wstrb[b])
            ram[idx][8*b +: 8] <= mem.wdata[8*b +: 8];
        end
      end else begin
        mem.rdata <= ram[idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top import fetch_pkg::*; #(
  parameter int LINES       = 8,
  parameter int LINE_WORDS  = 4,
  parameter int MEM_WORDS   = 1024,
  parameter int MEM_LATENCY = 3
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        stall_i,
  input  wire        redirect_i,
  input  wire xlen_t redirect_pc_i,
  output xlen_t      inst_o,
  output xlen_t      pc_o,
  output logic       inst_valid_o,
  input  wire        dmem_req_i,
  input  wire        dmem_we_i,
  input  wire xlen_t dmem_addr_i,
  input  wire xlen_t dmem_wdata_i,
  input  wire strb_t dmem_wstrb_i,
  output logic       dmem_ack_o,
  output xlen_t      dmem_rdata_o
);

  mem_req_if fetch_if ();   // pc_gen to icache
  mem_req_if refill_if ();  // icache to arbiter
  mem_req_if mem_if ();     // arbiter to memory

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch         (fetch_if.requester),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_valid_o  (inst_valid_o)
  );

  icache #(
    .LINES      (LINES),
    .LINE_WORDS (LINE_WORDS)
  ) u_icache (
    .clk    (clk),
    .rst_n  (rst_n),
    .fetch  (fetch_if.responder),
    .refill (refill_if.requester)
  );

  mem_arbiter u_mem_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .refill       (refill_if.responder),
    .mem          (mem_if.requester),
    .dmem_req_i   (dmem_req_i),
    .dmem_we_i    (dmem_we_i),
    .dmem_addr_i  (dmem_addr_i),
    .dmem_wdata_i (dmem_wdata_i),
    .dmem_wstrb_i (dmem_wstrb_i),
    .dmem_ack_o   (dmem_ack_o),
    .dmem_rdata_o (dmem_rdata_o)
  );

  mem_model #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_mem_model (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (mem_if.responder)
  );

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release shortly after an edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #5 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

  localparam int MEM_WORDS = 1024;
  localparam int N_READS   = 8;
  // about 110 fetches at up to 30 cycles each, 14 data ops, plus margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic  clk;
  logic  rst_n;
  logic  stall;
  logic  stall_en;      // random stalls on
  logic  redirect;
  xlen_t redirect_pc;
  logic  dmem_req;
  logic  dmem_we;
  xlen_t dmem_addr;
  xlen_t dmem_wdata;
  strb_t dmem_wstrb;
  xlen_t inst;
  xlen_t pc;
  logic  inst_valid;
  logic  dmem_ack;
  xlen_t dmem_rdata;

  xlen_t  shadow [MEM_WORDS];         // expected memory content
  logic   stall_pat [TIMEOUT_CYCLES];
  xlen_t  read_addr [N_READS];
  integer seed;
  xlen_t  exp_pc;
  int     consumed;
  int     cycles;
  logic   ack_q;
  string  test_name;

  clk_gen #(.PERIOD(40), .RST_CYCLES(4)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  fetch_top #(
    .LINES       (8),
    .LINE_WORDS  (4),
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (3)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .inst_o        (inst),
    .pc_o          (pc),
    .inst_valid_o  (inst_valid),
    .dmem_req_i    (dmem_req),
    .dmem_we_i     (dmem_we),
    .dmem_addr_i   (dmem_addr),
    .dmem_wdata_i  (dmem_wdata),
    .dmem_wstrb_i  (dmem_wstrb),
    .dmem_ack_o    (dmem_ack),
    .dmem_rdata_o  (dmem_rdata)
  );

  function automatic xlen_t ref_word(input xlen_t addr);
    return shadow[(addr >> 2) % MEM_WORDS];
  endfunction

  // byte-strobed merge of a write into the old word
  function automatic xlen_t merge_bytes(input xlen_t old_w, input xlen_t new_w, input strb_t strb);
    xlen_t res;
    int    b;
    res = old_w;
    for (b = 0; b < 4; b++) begin
      if (strb[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_inst(input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("Fail %s inst: expected %h, actual %h", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pc(input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("Fail %s pc: expected %h, actual %h", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_data(input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("Fail %s dmem rdata: expected %h, actual %h", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s flag: expected %b, actual %b", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_consumed(input int n);
    int target;
    target = consumed + n;
    while (consumed < target)
      next_cycle();
  endtask

  task automatic do_redirect(input xlen_t target_pc);
    next_cycle();
    redirect    = 1'b1;
    redirect_pc = target_pc;
    next_cycle();
    redirect = 1'b0;
  endtask

  // one four-phase transfer on the data port
  task automatic dmem_access(input logic we, input xlen_t addr, input xlen_t wdata,
                             input strb_t strb);
    next_cycle();
    dmem_we    = we;
    dmem_addr  = addr;
    dmem_wdata = wdata;
    dmem_wstrb = strb;
    dmem_req   = 1'b1;
    do next_cycle(); while (!dmem_ack);
    dmem_req = 1'b0;
    do next_cycle(); while (dmem_ack);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  always @(posedge clk) begin : drive_stall
    logic en;
    en = stall_en;  // sampled before the stimulus can change it
    #5;
    stall = en && stall_pat[cycles % TIMEOUT_CYCLES];
  end

  // checker, samples mid-cycle where all signals are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (redirect) begin
        exp_pc = redirect_pc;  // flushed, nothing consumed
      end else if (inst_valid && !stall) begin
        check_pc(exp_pc, pc);
        check_inst(ref_word(exp_pc), inst);
        exp_pc   = exp_pc + 32'd4;
        consumed = consumed + 1;
      end
      if (!inst_valid)
        check_inst(NOP_INST, inst);
      if (dmem_ack && !ack_q) begin
        if (dmem_we)
          shadow[(dmem_addr >> 2) % MEM_WORDS] =
            merge_bytes(ref_word(dmem_addr), dmem_wdata, dmem_wstrb);
        else
          check_data(ref_word(dmem_addr), dmem_rdata);
      end
      ack_q = dmem_ack;
    end
  end

  initial begin
    logic [31:0] rnd;
    int          i;
    stall       = 1'b0;
    stall_en    = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    dmem_req    = 1'b0;
    dmem_we     = 1'b0;
    dmem_addr   = '0;
    dmem_wdata  = '0;
    dmem_wstrb  = '0;
    exp_pc      = RESET_PC;
    consumed    = 0;
    cycles      = 0;
    ack_q       = 1'b0;
    test_name   = "reset";
    seed        = 32'h3165;
    for (i = 0; i < MEM_WORDS; i++)
      shadow[i] = mem_init_word(i);
    for (i = 0; i < TIMEOUT_CYCLES; i++) begin
      rnd          = $random(seed);
      stall_pat[i] = rnd[0];
    end
    for (i = 0; i < N_READS; i++) begin
      rnd          = $random(seed);
      read_addr[i] = {20'h0, rnd[9:0], 2'b00};
    end

    @(negedge clk);
    check_bit(1'b0, inst_valid);
    check_bit(1'b0, dmem_ack);
    @(posedge rst_n);

    test_name = "sequential";
    wait_consumed(24);

    test_name = "redirect";
    do_redirect(RESET_PC);  // loop back, lines already cached
    wait_consumed(16);
    do_redirect(32'h0000_0104);
    wait_consumed(6);

    test_name = "random_stall";
    stall_en = 1'b1;
    wait_consumed(24);
    do_redirect(32'h0000_0180);
    wait_consumed(8);

    test_name = "dmem_read";
    for (i = 0; i < N_READS; i++) begin
      dmem_access(1'b0, read_addr[i], '0, '0);
      next_cycle();
    end
    wait_consumed(8);
    stall_en = 1'b0;

    test_name = "dmem_write";
    dmem_access(1'b1, 32'h0000_0C00, 32'hA5A5_5A5A, 4'b1111);
    dmem_access(1'b1, 32'h0000_0C04, 32'h1122_3344, 4'b0011);
    dmem_access(1'b1, 32'h0000_0C08, 32'hDEAD_BEEF, 4'b1100);
    dmem_access(1'b1, 32'h0000_0C0C, 32'hCAFE_F00D, 4'b0101);
    dmem_access(1'b1, 32'h0000_0C00, 32'h0000_7700, 4'b0010);
    dmem_access(1'b0, 32'h0000_0C04, '0, '0);
    do_redirect(32'h0000_0C00);
    wait_consumed(8);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/fetch_pkg.sv
source/mem_req_if.sv
source/pc_gen.sv
source/icache.sv
source/mem_arbiter.sv
source/mem_model.sv
source/fetch_top.sv
verification/clk_gen.sv
verification/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  # design, package and interface first
  - source/fetch_pkg.sv
  - source/mem_req_if.sv
  - source/pc_gen.sv
  - source/icache.sv
  - source/mem_arbiter.sv
  - source/mem_model.sv
  - source/fetch_top.sv

  # testbench
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/fetch_tb.sv
